/* design/pcm_pkg.sv */
// PCM sample types for the stereo double buffer
// Word and pair types, bank geometry, DAC read sequencer states

package pcm_pkg;

  // One PCM sample word as stored in a bank
  typedef logic [31:0] pcm_word_t;

  // Stereo pair, left in the upper half
  typedef struct packed
  {
    pcm_word_t left;
    pcm_word_t right;
  } pcm_pair_t;

  // Bank geometry
  localparam int PCM_PAIRS_PER_BANK = 8;
  localparam int PCM_WORDS_PER_BANK = 2 * PCM_PAIRS_PER_BANK;  // Left and right per pair

  // Word address inside one bank, pair index in the upper bits
  localparam int PCM_MEM_ADDR_W     = $clog2(PCM_WORDS_PER_BANK);

  // DAC read sequencer
  // RD_LEFT   left word address presented to the bank
  // RD_RIGHT  right word address presented, left word on read data
  // RD_LOAD   right word on read data, pair goes out
  typedef enum logic [1:0]
  {
    RD_IDLE  = 2'd0,  // Waiting for first-word refresh or a DAC request
    RD_LEFT  = 2'd1,
    RD_RIGHT = 2'd2,
    RD_LOAD  = 2'd3
  } pcm_rd_state_e;

endpackage

/* design/lb_pkg.sv */
// Local bus definitions for the PCM buffer register block
// Request struct, register map, control bits, filler read word

package lb_pkg;

  localparam int LB_DATA_W = 32;
  localparam int LB_ADDR_W = 8;

  // Strobe request from the local bus master
  typedef struct packed
  {
    logic                 wr_en;    // Single cycle write strobe
    logic                 rd_en;    // Single cycle read strobe
    logic [LB_ADDR_W-1:0] addr;
    logic [LB_DATA_W-1:0] wr_data;
  } lb_req_t;

  // Register map
  typedef enum logic [LB_ADDR_W-1:0]
  {
    REG_CONTROL  = 8'd0,  // Mode select
    REG_STATUS   = 8'd1,  // Capture done flag
    REG_CAP_ADDR = 8'd2,  // Word address for capture readback
    REG_CAP_DATA = 8'd3   // Captured word at that address
  } lb_reg_e;

  // Read data for addresses outside the map
  localparam logic [LB_DATA_W-1:0] LB_FILLER_WORD = 32'hdead_babe;

  // REG_CONTROL bit, 1 selects capture mode
  localparam int CTRL_CAPTURE_BIT = 0;

endpackage

/* design/pcm_bank_ram.sv */
// Behavioral PCM bank memory
// One write port, one read port, registered read data

`timescale 1ns/1ns

module pcm_bank_ram import pcm_pkg::*;
(
  input  logic                      acortex_clk,
  input  logic                      wr_en,
  input  logic [PCM_MEM_ADDR_W-1:0] waddr,
  input  pcm_word_t                 wdata,
  input  logic [PCM_MEM_ADDR_W-1:0] raddr,
  output pcm_word_t                 rdata
);

  // Left/right words of all pairs in the bank
  pcm_word_t mem [PCM_WORDS_PER_BANK];

  // Write port
  always_ff @(posedge acortex_clk)
  begin
    if (wr_en)
    begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge acortex_clk)
  begin
    rdata <= mem[raddr];  // Old data on same-address collision
  end

endmodule

/* design/pcm_bffr_regs.sv */
// Local bus register block of the PCM buffer
// Control, status, capture address and capture data registers
// Owns the capture mode bit and the capture done flag

`timescale 1ns/1ns

module pcm_bffr_regs import lb_pkg::*, pcm_pkg::*;
(
  input  logic                      acortex_clk,
  input  logic                      acortex_rst_n,

  input  lb_req_t                   lb_req,
  output logic                      lb_wr_valid,
  output logic                      lb_rd_valid,
  output logic [LB_DATA_W-1:0]      lb_rd_data,

  input  logic                      bank_full,    // Pulse from buffer core
  input  pcm_word_t                 cap_rdata,    // Bank A word at cap_addr

  output logic                      ctrl_wr,      // Control register written
  output logic                      capture_mode,
  output logic [PCM_MEM_ADDR_W-1:0] cap_addr
);

  logic                 cap_done;   // Capture bank filled
  logic                 cap_addr_wr;
  logic [LB_DATA_W-1:0] rd_word;    // Read mux result

  // Write decode
  assign ctrl_wr     = lb_req.wr_en && (lb_req.addr == REG_CONTROL);
  assign cap_addr_wr = lb_req.wr_en && (lb_req.addr == REG_CAP_ADDR);

  // Control and capture address registers
  always_ff @(posedge acortex_clk or negedge acortex_rst_n)
  begin
    if (!acortex_rst_n)
    begin
      capture_mode <= 1'b0;
      cap_addr     <= '0;
    end
    else
    begin
      if (ctrl_wr)
      begin
        capture_mode <= lb_req.wr_data[CTRL_CAPTURE_BIT];
      end
      if (cap_addr_wr)
      begin
        cap_addr <= lb_req.wr_data[PCM_MEM_ADDR_W-1:0];  // Upper bits dropped
      end
    end
  end

  // Capture done flag
  // Any control write restarts the capture, so it clears here first
  always_ff @(posedge acortex_clk or negedge acortex_rst_n)
  begin
    if (!acortex_rst_n)
    begin
      cap_done <= 1'b0;
    end
    else if (ctrl_wr)
    begin
      cap_done <= 1'b0;
    end
    else if (bank_full && capture_mode)
    begin
      cap_done <= 1'b1;  // Sticky until next control write
    end
  end

  // Read mux
  always_comb
  begin
    rd_word = '0;
    case (lb_req.addr)
      REG_CONTROL:
      begin
        rd_word[CTRL_CAPTURE_BIT] = capture_mode;
      end
      REG_STATUS:
      begin
        rd_word[0] = cap_done;
      end
      REG_CAP_ADDR:
      begin
        rd_word[PCM_MEM_ADDR_W-1:0] = cap_addr;
      end
      REG_CAP_DATA:
      begin
        rd_word = cap_rdata;  // Bank A, two cycles behind cap_addr
      end
      default:
      begin
        rd_word = LB_FILLER_WORD;
      end
    endcase
  end

  // Bus response, valids one cycle after the strobes
  always_ff @(posedge acortex_clk or negedge acortex_rst_n)
  begin
    if (!acortex_rst_n)
    begin
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
      lb_rd_data  <= '0;
    end
    else
    begin
      lb_wr_valid <= lb_req.wr_en;
      lb_rd_valid <= lb_req.rd_en;
      if (lb_req.rd_en)
      begin
        lb_rd_data <= rd_word;  // Held until next read
      end
    end
  end

endmodule

/* design/pcm_bffr.sv */
// PCM double buffer core
// ADC write sequencing, bank select, bank full detection
// DAC pair read sequencer with first-word fall-through, capture readback

`timescale 1ns/1ns

module pcm_bffr import pcm_pkg::*;
(
  input  logic                      acortex_clk,
  input  logic                      acortex_rst_n,

  input  logic                      ctrl_wr,
  input  logic                      capture_mode,
  input  logic [PCM_MEM_ADDR_W-1:0] cap_addr,
  output logic                      bank_full,
  output pcm_word_t                 cap_rdata,

  input  logic                      adc_pcm_valid,
  input  pcm_pair_t                 adc_pair,

  output logic                      dac_data_rdy,
  input  logic                      dac_pcm_nxt,
  output pcm_pair_t                 dac_pair,

  output logic                      bank_a_wr_en,
  output logic                      bank_b_wr_en,
  output logic [PCM_MEM_ADDR_W-1:0] mem_waddr,
  output pcm_word_t                 mem_wdata,
  output logic [PCM_MEM_ADDR_W-1:0] mem_raddr,
  input  pcm_word_t                 bank_a_rdata,
  input  pcm_word_t                 bank_b_rdata
);

  // Write side
  logic          adc_accept;   // Strobe taken into the write path
  logic          adc_left_q;   // Left word write cycle
  logic          adc_right_q;  // Right word write cycle
  pcm_pair_t     adc_pair_q;
  logic          wr_active;
  logic          wr_bank;      // 0 = bank A, 1 = bank B
  logic          filled_bank;  // Most recently filled bank
  logic          cap_lock;     // Capture bank full, ADC ignored

  // Read side
  pcm_rd_state_e rd_state;
  logic [$clog2(PCM_PAIRS_PER_BANK)-1:0] rd_pair;
  logic [$clog2(PCM_PAIRS_PER_BANK)-1:0] rd_pair_nxt;
  logic          rd_bank;
  logic          dac_data_rdy_q;
  logic          rdy_rise;     // First-word refresh
  logic          rd_req;
  pcm_word_t     rd_word;
  pcm_word_t     left_hold;

  assign adc_accept = adc_pcm_valid && !(capture_mode && cap_lock);
  assign wr_active  = adc_left_q || adc_right_q;
  assign mem_wdata  = adc_left_q ? adc_pair_q.left : adc_pair_q.right;

  assign bank_a_wr_en = wr_active && !wr_bank;
  assign bank_b_wr_en = wr_active && wr_bank;

  // Last right word of the bank going in
  assign bank_full = adc_right_q && (mem_waddr == PCM_MEM_ADDR_W'(PCM_WORDS_PER_BANK - 1));

  // ADC pair register
  always_ff @(posedge acortex_clk)
  begin
    if (adc_accept)
    begin
      adc_pair_q <= adc_pair;
    end
  end

  // Write address, bank toggle, ready level
  always_ff @(posedge acortex_clk or negedge acortex_rst_n)
  begin
    if (!acortex_rst_n)
    begin
      adc_left_q   <= 1'b0;
      adc_right_q  <= 1'b0;
      mem_waddr    <= '0;
      wr_bank      <= 1'b0;
      filled_bank  <= 1'b0;
      cap_lock     <= 1'b0;
      dac_data_rdy <= 1'b0;
    end
    else
    begin
      adc_left_q  <= adc_accept;
      adc_right_q <= adc_left_q;  // Right word one cycle after left
      if (ctrl_wr)
      begin
        mem_waddr    <= '0;     // Restart at bank A word 0
        wr_bank      <= 1'b0;
        cap_lock     <= 1'b0;
        dac_data_rdy <= 1'b0;
      end
      else
      begin
        if (wr_active)
        begin
          mem_waddr <= mem_waddr + PCM_MEM_ADDR_W'(1);  // Wraps into next bank
        end
        if (bank_full)
        begin
          filled_bank <= wr_bank;
          if (capture_mode)
          begin
            cap_lock <= 1'b1;  // Bank A only, once
          end
          else
          begin
            wr_bank      <= ~wr_bank;  // Ping-pong
            dac_data_rdy <= 1'b1;
          end
        end
      end
    end
  end

  // Read request sources
  assign rdy_rise    = dac_data_rdy && !dac_data_rdy_q;
  assign rd_req      = rdy_rise || (dac_pcm_nxt && dac_data_rdy);
  assign rd_pair_nxt = rdy_rise ? '0 : rd_pair + 1'b1;  // Natural wrap after last pair
  assign rd_word     = rd_bank ? bank_b_rdata : bank_a_rdata;
  assign cap_rdata   = bank_a_rdata;  // Capture always lands in bank A

  // Left word arrives while in RD_RIGHT
  always_ff @(posedge acortex_clk)
  begin
    if (rd_state == RD_RIGHT)
    begin
      left_hold <= rd_word;
    end
  end

  // DAC read sequencer and read address
  always_ff @(posedge acortex_clk or negedge acortex_rst_n)
  begin
    if (!acortex_rst_n)
    begin
      rd_state       <= RD_IDLE;
      rd_pair        <= '0;
      rd_bank        <= 1'b0;
      mem_raddr      <= '0;
      dac_pair       <= '0;
      dac_data_rdy_q <= 1'b0;
    end
    else
    begin
      dac_data_rdy_q <= dac_data_rdy;
      if (ctrl_wr)
      begin
        rd_state <= RD_IDLE;  // Abandon any pair in flight
        rd_pair  <= '0;
      end
      else
      begin
        case (rd_state)
          RD_IDLE:
          begin
            if (rd_req)
            begin
              rd_state  <= RD_LEFT;
              rd_pair   <= rd_pair_nxt;
              mem_raddr <= {rd_pair_nxt, 1'b0};  // Left word address
              if (rdy_rise || (rd_pair_nxt == '0))
              begin
                rd_bank <= filled_bank;  // New pass starts on latest filled bank
              end
            end
          end
          RD_LEFT:
          begin
            rd_state  <= RD_RIGHT;
            mem_raddr <= {rd_pair, 1'b1};  // Right word address
          end
          RD_RIGHT:
          begin
            rd_state <= RD_LOAD;
          end
          RD_LOAD:
          begin
            rd_state <= RD_IDLE;
            dac_pair <= '{left: left_hold, right: rd_word};
          end
          default:
          begin
            rd_state <= RD_IDLE;
          end
        endcase
      end
      if (capture_mode)
      begin
        mem_raddr <= cap_addr;  // Local bus readback owns the read port
      end
    end
  end

endmodule

/* design/acortex_pcm_top.sv */
// Top level of the stereo PCM double buffer
// Register block, buffer core and the two bank memories

`timescale 1ns/1ns

module acortex_pcm_top import lb_pkg::*, pcm_pkg::*;
(
  input  logic                 acortex_clk,
  input  logic                 acortex_rst_n,

  input  lb_req_t              lb_req,
  output logic                 lb_wr_valid,
  output logic                 lb_rd_valid,
  output logic [LB_DATA_W-1:0] lb_rd_data,

  input  logic                 adc_pcm_valid,
  input  pcm_pair_t            adc_pair,

  output logic                 dac_data_rdy,
  input  logic                 dac_pcm_nxt,
  output pcm_pair_t            dac_pair
);

  // Register block to core
  logic                      ctrl_wr;
  logic                      capture_mode;
  logic [PCM_MEM_ADDR_W-1:0] cap_addr;
  logic                      bank_full;
  pcm_word_t                 cap_rdata;

  // Core to banks, shared address and data
  logic                      bank_a_wr_en;
  logic                      bank_b_wr_en;
  logic [PCM_MEM_ADDR_W-1:0] mem_waddr;
  pcm_word_t                 mem_wdata;
  logic [PCM_MEM_ADDR_W-1:0] mem_raddr;
  pcm_word_t                 bank_a_rdata;
  pcm_word_t                 bank_b_rdata;

  pcm_bffr_regs pcm_bffr_regs_i
  (
    .acortex_clk   (acortex_clk),
    .acortex_rst_n (acortex_rst_n),
    .lb_req        (lb_req),
    .lb_wr_valid   (lb_wr_valid),
    .lb_rd_valid   (lb_rd_valid),
    .lb_rd_data    (lb_rd_data),
    .bank_full     (bank_full),
    .cap_rdata     (cap_rdata),
    .ctrl_wr       (ctrl_wr),
    .capture_mode  (capture_mode),
    .cap_addr      (cap_addr)
  );

  pcm_bffr pcm_bffr_i
  (
    .acortex_clk   (acortex_clk),
    .acortex_rst_n (acortex_rst_n),
    .ctrl_wr       (ctrl_wr),
    .capture_mode  (capture_mode),
    .cap_addr      (cap_addr),
    .bank_full     (bank_full),
    .cap_rdata     (cap_rdata),
    .adc_pcm_valid (adc_pcm_valid),
    .adc_pair      (adc_pair),
    .dac_data_rdy  (dac_data_rdy),
    .dac_pcm_nxt   (dac_pcm_nxt),
    .dac_pair      (dac_pair),
    .bank_a_wr_en  (bank_a_wr_en),
    .bank_b_wr_en  (bank_b_wr_en),
    .mem_waddr     (mem_waddr),
    .mem_wdata     (mem_wdata),
    .mem_raddr     (mem_raddr),
    .bank_a_rdata  (bank_a_rdata),
    .bank_b_rdata  (bank_b_rdata)
  );

  // Bank A, also the capture bank
  pcm_bank_ram bank_a_i
  (
    .acortex_clk (acortex_clk),
    .wr_en       (bank_a_wr_en),
    .waddr       (mem_waddr),
    .wdata       (mem_wdata),
    .raddr       (mem_raddr),
    .rdata       (bank_a_rdata)
  );

  pcm_bank_ram bank_b_i
  (
    .acortex_clk (acortex_clk),
    .wr_en       (bank_b_wr_en),
    .waddr       (mem_waddr),
    .wdata       (mem_wdata),
    .raddr       (mem_raddr),
    .rdata       (bank_b_rdata)
  );

endmodule

/* bench/pcm_tb_assertions.sv */
// Bound concurrent checks for the PCM buffer
// Bus valid timing, dac_data_rdy fall condition, cap_done mode check

`timescale 1ns/1ns

module pcm_tb_assertions
(
  input logic acortex_clk,
  input logic acortex_rst_n,
  input logic wr_en,         // Local bus write strobe
  input logic rd_en,         // Local bus read strobe
  input logic lb_wr_valid,
  input logic lb_rd_valid,
  input logic ctrl_wr,
  input logic capture_mode,
  input logic cap_done,
  input logic dac_data_rdy
);

  // Write valid is the enable delayed by one cycle
  wr_valid_follows: assert property (@(posedge acortex_clk) disable iff (!acortex_rst_n)
    lb_wr_valid == $past(wr_en))
    else $error("lb_wr_valid does not follow the write enable by one cycle");

  // Same for the read side
  rd_valid_follows: assert property (@(posedge acortex_clk) disable iff (!acortex_rst_n)
    lb_rd_valid == $past(rd_en))
    else $error("lb_rd_valid does not follow the read enable by one cycle");

  // Ready level only drops after a control write
  rdy_fall_on_ctrl: assert property (@(posedge acortex_clk) disable iff (!acortex_rst_n)
    $fell(dac_data_rdy) |-> $past(ctrl_wr))
    else $error("dac_data_rdy fell without a control write");

  // Capture flag lives only in capture mode
  cap_done_in_capture: assert property (@(posedge acortex_clk) disable iff (!acortex_rst_n)
    cap_done |-> capture_mode)
    else $error("cap_done set outside capture mode");

endmodule

// Register block side, no DAC ready here
bind pcm_bffr_regs pcm_tb_assertions regs_checks_i
(
  .acortex_clk   (acortex_clk),
  .acortex_rst_n (acortex_rst_n),
  .wr_en         (lb_req.wr_en),
  .rd_en         (lb_req.rd_en),
  .lb_wr_valid   (lb_wr_valid),
  .lb_rd_valid   (lb_rd_valid),
  .ctrl_wr       (ctrl_wr),
  .capture_mode  (capture_mode),
  .cap_done      (cap_done),
  .dac_data_rdy  (1'b0)
);

// Core side, bus ports tied off
bind pcm_bffr pcm_tb_assertions core_checks_i
(
  .acortex_clk   (acortex_clk),
  .acortex_rst_n (acortex_rst_n),
  .wr_en         (1'b0),
  .rd_en         (1'b0),
  .lb_wr_valid   (1'b0),
  .lb_rd_valid   (1'b0),
  .ctrl_wr       (ctrl_wr),
  .capture_mode  (capture_mode),
  .cap_done      (1'b0),
  .dac_data_rdy  (dac_data_rdy)
);

/* bench/pcm_tb.sv */
// Testbench for the stereo PCM double buffer
// Clock, reset, ADC and DAC stimulus, local bus access
// Reference model of pairs and registers, compare task, watchdog

`timescale 1ns/1ns

module pcm_tb import lb_pkg::*, pcm_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DLY    = 2;   // Inputs change after the edge
  localparam int RESET_CYCLES = 10;
  localparam int ADC_GAP      = 4;   // Cycles between ADC strobes
  localparam int DAC_IDLE     = 3;   // Gives 8 cycles between DAC requests
  localparam int POLL_LIMIT   = 50;

  // Rough phase lengths in cycles
  localparam int RESET_LEN   = RESET_CYCLES + 20;
  localparam int REGS_LEN    = 60;
  localparam int BANK_LEN    = PCM_PAIRS_PER_BANK * ADC_GAP + 8;
  localparam int REQ_LEN     = 9;
  localparam int NORMAL_LEN  = 3 * BANK_LEN + 3 * PCM_PAIRS_PER_BANK * REQ_LEN;
  localparam int CAPTURE_LEN = BANK_LEN + 3 * ADC_GAP + 3 * POLL_LIMIT
                               + PCM_WORDS_PER_BANK * 10;
  localparam int RESTART_LEN = 30 + BANK_LEN + 4 * REQ_LEN;
  localparam int MARGIN      = 200;
  localparam int TIMEOUT_NS  = (RESET_LEN + REGS_LEN + NORMAL_LEN + CAPTURE_LEN
                               + RESTART_LEN + MARGIN) * CLK_PERIOD;

  logic                 acortex_clk;
  logic                 acortex_rst_n;
  lb_req_t              lb_req;
  logic                 lb_wr_valid;
  logic                 lb_rd_valid;
  logic [LB_DATA_W-1:0] lb_rd_data;
  logic                 adc_pcm_valid;
  pcm_pair_t            adc_pair;
  logic                 dac_data_rdy;
  logic                 dac_pcm_nxt;
  pcm_pair_t            dac_pair;

  // Reference model state
  pcm_pair_t                 sent_q[$];   // Normal mode pairs in ADC order
  int                        next_idx;    // Next pair the DAC should see
  logic                      model_capture;
  logic                      model_cap_done;
  logic [PCM_MEM_ADDR_W-1:0] model_cap_addr;
  pcm_word_t                 cap_words [PCM_WORDS_PER_BANK];
  integer                    seed = 41;

  acortex_pcm_top acortex_pcm_top_i
  (
    .acortex_clk   (acortex_clk),
    .acortex_rst_n (acortex_rst_n),
    .lb_req        (lb_req),
    .lb_wr_valid   (lb_wr_valid),
    .lb_rd_valid   (lb_rd_valid),
    .lb_rd_data    (lb_rd_data),
    .adc_pcm_valid (adc_pcm_valid),
    .adc_pair      (adc_pair),
    .dac_data_rdy  (dac_data_rdy),
    .dac_pcm_nxt   (dac_pcm_nxt),
    .dac_pair      (dac_pair)
  );

  initial acortex_clk = 1'b0;
  always #(CLK_PERIOD / 2) acortex_clk = ~acortex_clk;  // 20 ns period

  // Expected pair at a delivery index
  function automatic pcm_pair_t ref_pair(input int idx);
    return sent_q[idx];
  endfunction

  // Expected register read word
  function automatic logic [LB_DATA_W-1:0] ref_reg(input logic [LB_ADDR_W-1:0] addr);
    logic [LB_DATA_W-1:0] word;
    word = '0;
    case (addr)
      REG_CONTROL:  word[CTRL_CAPTURE_BIT] = model_capture;
      REG_STATUS:   word[0] = model_cap_done;
      REG_CAP_ADDR: word[PCM_MEM_ADDR_W-1:0] = model_cap_addr;
      REG_CAP_DATA: word = cap_words[model_cap_addr];  // Bank A snapshot
      default:      word = LB_FILLER_WORD;
    endcase
    return word;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    if (actual !== expected)
    begin
      fail_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                         $time, msg, actual, expected));
    end
  endtask

  task automatic lb_write(input logic [LB_ADDR_W-1:0] addr, input logic [LB_DATA_W-1:0] data);
    @(posedge acortex_clk);
    #DRIVE_DLY;
    lb_req.wr_en   = 1'b1;
    lb_req.addr    = addr;
    lb_req.wr_data = data;
    @(posedge acortex_clk);
    #DRIVE_DLY;
    lb_req.wr_en = 1'b0;
    check_value(64'(lb_wr_valid), 64'd1, "write valid one cycle after enable");
  endtask

  task automatic lb_read(input logic [LB_ADDR_W-1:0] addr, output logic [LB_DATA_W-1:0] data);
    @(posedge acortex_clk);
    #DRIVE_DLY;
    lb_req.rd_en = 1'b1;
    lb_req.addr  = addr;
    @(posedge acortex_clk);
    #DRIVE_DLY;
    lb_req.rd_en = 1'b0;
    check_value(64'(lb_rd_valid), 64'd1, "read valid one cycle after enable");
    data = lb_rd_data;  // Valid with lb_rd_valid
  endtask

  task automatic read_check(input logic [LB_ADDR_W-1:0] addr, input string msg);
    logic [LB_DATA_W-1:0] data;
    lb_read(addr, data);
    check_value(64'(data), 64'(ref_reg(addr)), msg);
  endtask

  // Control write also clears the capture flag in the model
  task automatic write_control(input logic [LB_DATA_W-1:0] data);
    lb_write(REG_CONTROL, data);
    model_capture  = data[CTRL_CAPTURE_BIT];
    model_cap_done = 1'b0;
  endtask

  task automatic write_cap_addr(input logic [LB_DATA_W-1:0] data);
    lb_write(REG_CAP_ADDR, data);
    model_cap_addr = data[PCM_MEM_ADDR_W-1:0];  // Only word address bits kept
  endtask

  // One ADC strobe with a random pair
  task automatic feed_pair(output pcm_pair_t pair);
    pair.left  = $random(seed);
    pair.right = $random(seed);
    @(posedge acortex_clk);
    #DRIVE_DLY;
    adc_pair      = pair;
    adc_pcm_valid = 1'b1;
    @(posedge acortex_clk);
    #DRIVE_DLY;
    adc_pcm_valid = 1'b0;
    repeat (ADC_GAP - 2) @(posedge acortex_clk);
  endtask

  task automatic feed_bank();
    pcm_pair_t pair;
    repeat (PCM_PAIRS_PER_BANK)
    begin
      feed_pair(pair);
      sent_q.push_back(pair);
    end
  endtask

  task automatic wait_rdy();
    int n;
    n = 0;
    #1;
    while (!dac_data_rdy)
    begin
      @(posedge acortex_clk);
      #1;
      n++;
      if (n > POLL_LIMIT)
      begin
        fail_run("dac_data_rdy never rose after a full bank was written");
      end
    end
  endtask

  // First pair shows up without a request
  task automatic check_first_pair();
    wait_rdy();
    repeat (4) @(posedge acortex_clk);
    #1;
    check_value(dac_pair, ref_pair(0), "first pair after dac_data_rdy");
    next_idx = 1;
  endtask

  // One DAC request, pair checked 4 cycles after the pulse
  task automatic dac_request();
    #1;
    check_value(dac_pair, ref_pair(next_idx - 1), "dac_pair steady between requests");
    @(posedge acortex_clk);
    #DRIVE_DLY;
    dac_pcm_nxt = 1'b1;
    @(posedge acortex_clk);
    #DRIVE_DLY;
    dac_pcm_nxt = 1'b0;
    repeat (3) @(posedge acortex_clk);
    #1;
    check_value(dac_pair, ref_pair(next_idx), $sformatf("dac pair %0d", next_idx));
    next_idx++;
    repeat (DAC_IDLE) @(posedge acortex_clk);
  endtask

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    fail_run("Timeout: the test phases did not finish in the expected time");
  end

  initial
  begin
    logic [LB_DATA_W-1:0] data;
    pcm_pair_t            pair;
    int                   polls;

    acortex_rst_n  = 1'b0;
    lb_req         = '0;
    adc_pcm_valid  = 1'b0;
    adc_pair       = '0;
    dac_pcm_nxt    = 1'b0;
    model_capture  = 1'b0;
    model_cap_done = 1'b0;
    model_cap_addr = '0;
    next_idx       = 0;
    foreach (cap_words[i])
    begin
      cap_words[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge acortex_clk);
    #DRIVE_DLY;
    acortex_rst_n = 1'b1;

    // Reset state
    check_value(64'(dac_data_rdy), 64'd0, "dac_data_rdy after reset");
    check_value(dac_pair, 64'd0, "dac_pair after reset");
    read_check(REG_CONTROL, "control after reset");
    read_check(REG_STATUS, "status after reset");

    // Register access
    write_control(32'hffff_fff1);
    read_check(REG_CONTROL, "control readback set");
    write_control(32'h0000_0000);
    read_check(REG_CONTROL, "control readback clear");
    write_cap_addr(32'h0000_005a);
    read_check(REG_CAP_ADDR, "capture address readback");
    read_check(8'h40, "unmapped address filler");

    // Normal mode, first bank into A
    feed_bank();
    check_first_pair();
    repeat (3) dac_request();

    // Ping-pong, bank B filled while A drains
    fork
      feed_bank();
      repeat (4) dac_request();
    join
    repeat (2) @(posedge acortex_clk);
    dac_request();  // Wraps to bank B
    fork
      feed_bank();  // Third bank back into A
      repeat (7) dac_request();
    join
    repeat (2) @(posedge acortex_clk);
    repeat (8) dac_request();  // Wrap to A, third bank
    check_value(64'(dac_data_rdy), 64'd1, "dac_data_rdy held in normal mode");

    // Capture mode, 8 pairs plus 3 that must be dropped
    write_control(32'h0000_0001);
    check_value(64'(dac_data_rdy), 64'd0, "dac_data_rdy cleared by control write");
    for (int i = 0; i < PCM_PAIRS_PER_BANK + 3; i++)
    begin
      feed_pair(pair);
      if (i < PCM_PAIRS_PER_BANK)
      begin
        cap_words[2 * i]     = pair.left;
        cap_words[2 * i + 1] = pair.right;
      end
    end
    polls = 0;
    data  = '0;
    while (!data[0])
    begin
      lb_read(REG_STATUS, data);
      polls++;
      if (polls > POLL_LIMIT)
      begin
        fail_run("cap_done never set after the capture bank was filled");
      end
    end
    model_cap_done = 1'b1;
    read_check(REG_STATUS, "status with capture done");
    read_check(REG_CONTROL, "control in capture mode");
    for (int w = 0; w < PCM_WORDS_PER_BANK; w++)
    begin
      write_cap_addr(32'(w));
      repeat (3) @(posedge acortex_clk);  // Address to RAM read data
      read_check(REG_CAP_DATA, $sformatf("captured word %0d", w));
    end

    // Back to normal mode, delivery restarts
    write_control(32'h0000_0000);
    check_value(64'(dac_data_rdy), 64'd0, "dac_data_rdy after control rewrite");
    read_check(REG_STATUS, "cap_done cleared by control write");
    sent_q.delete();
    next_idx = 0;
    feed_bank();
    check_first_pair();
    repeat (3) dac_request();

    $display("All checks passed");
    $finish;
  end

endmodule

/* tb.f */
design/pcm_pkg.sv
design/lb_pkg.sv
design/pcm_bank_ram.sv
design/pcm_bffr_regs.sv
design/pcm_bffr.sv
design/acortex_pcm_top.sv
bench/pcm_tb_assertions.sv
bench/pcm_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PCM buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module pcm_tb -o pcm_sim \
  && ./obj_dir/pcm_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Checks failed" sim.log 2>/dev/null && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log 2>/dev/null || { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"
exit 0
